// File: src/opcodePkg.sv
// Opcode byte definitions shared by the fetch stage and the decode table
package opcodePkg;

    typedef logic [2:0] opField3;           // Operation or addressing mode field
    typedef logic [1:0] opField2;           // Group field

    // Field layout of the opcode byte as the decoder sees it
    typedef struct packed {
        opField3 opA;                       // Operation, bits 7..5
        opField3 opB;                       // Addressing mode, bits 4..2
        opField2 opC;                       // Group, bits 1..0
    } opFields;

    // One byte with two readings. Fetch treats it as a raw byte
    typedef union packed {
        logic [7:0] raw;                    // Bus byte, loaded or injected
        opFields    fields;                 // Decoded view
    } opcodeWord;

    localparam logic [7:0] brkOpcode = 8'h00;   // BRK, forced in on IRQ

    localparam opField3 storeOp = 3'b100;   // opA of STA/STX/STY

    localparam opField2 grpCtl  = 2'b00;    // Control and index ops
    localparam opField2 grpAlu  = 2'b01;    // Accumulator ALU ops
    localparam opField2 grpRmw  = 2'b10;    // Shift/rotate, X loads and stores
    localparam opField2 grpNone = 2'b11;    // Unused on this core

endpackage

// File: src/timingPkg.sv
// Timing state definitions shared by the T-state sequencer and the decode table
package timingPkg;

    localparam int tCount = 6;              // T0 up to T5

    // One-hot cycle state, bit k set means Tk
    typedef logic [tCount-1:0] tStateVec;

    localparam tStateVec tResetState = tStateVec'(1);  // T0, opcode fetch

    // Instruction length in cycles, 2 to 6
    typedef logic [2:0] cycleCount;

endpackage

// File: src/fetchStage.sv
// Opcode fetch with IRQ break injection, loads the instruction register at T0
module fetchStage
    import opcodePkg::*;
(
    input  logic       NMI_L,               // Core clock
    input  logic       rstN,                // Sync reset, active low
    input  logic [7:0] dataIn,              // Data bus byte
    input  logic       irqL,                // Interrupt request, active low
    input  logic       sync,                // High in the fetch cycle
    input  logic       RDY,                 // Ready from memory
    input  logic       nRW,                 // Low on a write cycle
    output opcodeWord  ir,                  // Instruction register
    output logic       irqTaken             // One cycle after a break injection
);

    logic      advance;                     // Cycle completes on this edge
    logic      fetchEdge;                   // Opcode load on this edge
    logic      inject;                      // Break replaces the bus byte
    logic      irqPending;                  // Latched IRQ request
    opcodeWord nextIr;                      // Byte to load into ir

    // Writes never wait on RDY
    assign advance   = RDY | ~nRW;
    assign fetchEdge = advance & sync;
    assign inject    = fetchEdge & irqPending;

    // Pending IRQ wins over the fetched byte
    always_comb begin
        if (irqPending) begin
            nextIr.raw = brkOpcode;
        end else begin
            nextIr.raw = dataIn;
        end
    end

    always_ff @(posedge NMI_L) begin
        if (!rstN) begin
            irqPending <= 1'b0;
            irqTaken   <= 1'b0;
            ir.raw     <= brkOpcode;        // Idle on a break
        end else begin
            irqTaken <= inject;             // Flags the injected fetch
            if (fetchEdge) begin
                ir <= nextIr;               // Same edge as the T0 exit
            end
            // Clear on injection beats a fresh sample
            if (inject) begin
                irqPending <= 1'b0;
            end else if (!irqL) begin
                irqPending <= 1'b1;         // Sampled even in a stall
            end
        end
    end

    // Break lasts six cycles, so no back-to-back injections
    irqTakenSingle: assert property (
        @(posedge NMI_L) disable iff (!rstN)
        irqTaken |=> !irqTaken
    ) else $error("irqTaken high on two consecutive cycles");

endmodule

// File: src/timingSequencer.sv
// One-hot T-state counter gated by the RDY/nRW ready rule, drives the sync strobe
module timingSequencer
    import timingPkg::*;
(
    input  logic     NMI_L,                 // Core clock
    input  logic     rstN,                  // Sync reset, active low
    input  logic     RDY,                   // Ready from memory
    input  logic     nRW,                   // Low on a write cycle
    input  logic     lastCycle,             // Final cycle of the instruction
    output tStateVec tState,                // Current T-state
    output logic     sync                   // High in T0
);

    logic     advance;                      // Move to the next state
    tStateVec nextState;                    // State after this cycle

    // Running when RDY is high or the bus is writing
    assign advance = RDY | ~nRW;

    // Last cycle wraps to the fetch, otherwise step one state up
    always_comb begin
        if (lastCycle) begin
            nextState = tResetState;
        end else begin
            nextState = {tState[tCount-2:0], 1'b0};
        end
    end

    always_ff @(posedge NMI_L) begin
        if (!rstN) begin
            tState <= tResetState;          // Start in the fetch cycle
        end else if (advance) begin
            tState <= nextState;
        end
    end

    assign sync = (tState == tResetState);  // Opcode fetch cycle

    // State register holds exactly one T bit
    tStateOneHot: assert property (
        @(posedge NMI_L) disable iff (!rstN)
        $onehot(tState)
    ) else $error("tState not one-hot: %b", tState);

    // Decode must flag T5 as last, so the count wraps to T0
    tStateWrap: assert property (
        @(posedge NMI_L) disable iff (!rstN)
        (tState[tCount-1] && advance) |=> (tState == tResetState)
    ) else $error("tState advanced past T5");

endmodule

// File: src/decodePla.sv
// Reduced decode table, gives the last-cycle and write-cycle lines from ir and T-state
module decodePla
    import opcodePkg::*;
    import timingPkg::*;
(
    input  opcodeWord ir,                   // Instruction register
    input  tStateVec  tState,               // Current T-state
    output logic      lastCycle,            // Instruction ends this cycle
    output logic      nRW                   // Low on the store write cycle
);

    cycleCount  cycles;                     // Instruction length N
    logic [2:0] lastIdx;                    // Index of T(N-1)
    logic       inLast;                     // Currently in T(N-1)
    logic       storeWrite;                 // Store with a memory operand

    // Length table by group and addressing mode
    always_comb begin
        if (ir.raw == brkOpcode) begin
            cycles = 3'd6;                  // BRK, also the injected IRQ
        end else begin
            case (ir.fields.opC)
                grpAlu: begin
                    case (ir.fields.opB)
                        3'b000:  cycles = 3'd6;     // (zp,X)
                        3'b001:  cycles = 3'd3;     // zp
                        3'b010:  cycles = 3'd2;     // Immediate
                        3'b011:  cycles = 3'd4;     // abs
                        3'b100:  cycles = 3'd5;     // (zp),Y
                        default: cycles = 3'd4;     // zp,X and abs,X/Y
                    endcase
                end
                grpCtl, grpRmw: begin
                    case (ir.fields.opB)
                        3'b001:  cycles = 3'd3;     // zp
                        3'b011:  cycles = 3'd4;     // abs
                        3'b101:  cycles = 3'd4;     // zp,X
                        3'b111:  cycles = 3'd4;     // abs,X
                        default: cycles = 3'd2;     // Implied, immediate, accumulator
                    endcase
                end
                default: begin
                    cycles = 3'd2;          // grpNone treated as a NOP
                end
            endcase
        end
    end

    assign lastIdx = cycles - 3'd1;
    assign inLast  = tState[lastIdx];

    // T0 never ends an instruction
    assign lastCycle = inLast & ~tState[0];

    // Two-cycle forms like TXS have no memory write
    assign storeWrite = (ir.fields.opA == storeOp) &&
                        (ir.fields.opC != grpNone) &&
                        (cycles > 3'd2);

    assign nRW = ~(storeWrite & inLast);    // Write only in the final cycle

    // Fetch cycle is always a read, whatever the opcode in ir
    always_comb begin
        if (tState[0]) begin
            fetchIsRead: assert (nRW)
                else $error("nRW low in T0, ir %h", ir.raw);
        end
    end

endmodule

// File: src/frontEndTop.sv
// Processor front end top level, ties fetch, T-state sequencing and decode together
module frontEndTop
    import opcodePkg::*;
    import timingPkg::*;
(
    input  logic       NMI_L,               // Core clock
    input  logic       rstN,                // Sync reset, active low
    input  logic [7:0] dataIn,              // Data bus byte
    input  logic       RDY,                 // Ready from memory
    input  logic       irqL,                // Interrupt request, active low
    output logic       sync,                // Opcode fetch cycle
    output tStateVec   tState,              // Current T-state
    output opcodeWord  ir,                  // Instruction register
    output logic       nRW,                 // Bus direction, low writes
    output logic       irqTaken             // Break was injected
);

    logic lastCycle;                        // Decode to sequencer

    // Opcode capture and IRQ injection
    fetchStage fetchStageInst (
        .NMI_L    (NMI_L),
        .rstN     (rstN),
        .dataIn   (dataIn),
        .irqL     (irqL),
        .sync     (sync),
        .RDY      (RDY),
        .nRW      (nRW),
        .ir       (ir),
        .irqTaken (irqTaken)
    );

    // T0..T5 counter with ready stall
    timingSequencer timingSequencerInst (
        .NMI_L     (NMI_L),
        .rstN      (rstN),
        .RDY       (RDY),
        .nRW       (nRW),
        .lastCycle (lastCycle),
        .tState    (tState),
        .sync      (sync)
    );

    // Cycle count and store write lines
    decodePla decodePlaInst (
        .ir        (ir),
        .tState    (tState),
        .lastCycle (lastCycle),
        .nRW       (nRW)
    );

endmodule

// File: test/frontEndModel.svh
// Cycle-level reference of the front end, included into the testbench module
`ifndef FRONT_END_MODEL_SVH
`define FRONT_END_MODEL_SVH

int         mState;                         // Model T index, 0 to 5
logic [7:0] mIr;                            // Model instruction register
logic       mPending;                       // Model IRQ pending flag
logic       mTaken;                         // Model irqTaken

// Instruction length from the cycle-count table
function automatic int lengthOf(input logic [7:0] op);
    logic [2:0] mode;                       // Addressing mode bits
    mode = op[4:2];
    if (op == 8'h00) return 6;              // Break
    case (op[1:0])
        2'b01: begin
            if (mode == 3'b000) return 6;
            if (mode == 3'b001) return 3;
            if (mode == 3'b010) return 2;
            if (mode == 3'b100) return 5;
            return 4;                       // Indexed forms
        end
        2'b11: return 2;
        default: begin
            if (!mode[0]) return 2;         // Even modes are short
            if (mode == 3'b001) return 3;
            return 4;
        end
    endcase
endfunction

// Bus direction for the current model state
function automatic logic modelNrw();
    int n;
    n = lengthOf(mIr);
    if (mIr[7:5] == 3'b100 && mIr[1:0] != 2'b11 && n > 2 && mState == n - 1) return 1'b0;
    return 1'b1;
endfunction

task automatic modelReset();
    mState   = 0;
    mIr      = 8'h00;                       // Idles on a break
    mPending = 1'b0;
    mTaken   = 1'b0;
endtask

// One rising edge with the inputs that were on the pins
task automatic modelStep(input logic [7:0] bus, input logic rdy, input logic irqIn);
    logic adv;
    logic fetch;
    adv   = rdy | ~modelNrw();              // Writes ignore RDY
    fetch = adv && (mState == 0);
    mTaken = fetch && mPending;
    if (adv) begin
        if (mState != 0 && mState == lengthOf(mIr) - 1) mState = 0;
        else mState = mState + 1;
    end
    if (fetch && mPending) mPending = 1'b0; // Clear beats a new sample
    else if (!irqIn) mPending = 1'b1;
    if (fetch) mIr = mTaken ? 8'h00 : bus;
endtask

`endif

// File: test/frontEndTb.sv
// Random-stimulus testbench for frontEndTop that compares it with the included model every cycle
module frontEndTb
    import opcodePkg::*;
    import timingPkg::*;
();

    logic       NMI_L;                      // Clock
    logic       rstN;
    logic [7:0] dataIn;
    logic       RDY;
    logic       irqL;
    logic       sync;
    tStateVec   tState;
    opcodeWord  ir;
    logic       nRW;
    logic       irqTaken;
    integer     seed;                       // $random state

    `include "frontEndModel.svh"

    frontEndTop i_dut (
        .NMI_L    (NMI_L),
        .rstN     (rstN),
        .dataIn   (dataIn),
        .RDY      (RDY),
        .irqL     (irqL),
        .sync     (sync),
        .tState   (tState),
        .ir       (ir),
        .nRW      (nRW),
        .irqTaken (irqTaken)
    );

    initial begin
        NMI_L = 1'b0;
        forever #50 NMI_L = ~NMI_L;         // Period 100
    end

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("FAIL: see errors above");
        $fatal(1, "wait timed out");
    endtask

    task automatic compareModel();
        checkValue("tState", 32'(tState), 32'(1 << mState));
        checkValue("sync", 32'(sync), 32'(mState == 0));
        checkValue("ir", 32'(ir.raw), 32'(mIr));
        checkValue("nRW", 32'(nRW), 32'(modelNrw()));
        checkValue("irqTaken", 32'(irqTaken), 32'(mTaken));
    endtask

    // Runs from one falling edge to the next
    task automatic stepCycle(input logic [7:0] bus, input logic rdy, input logic irqIn);
        dataIn = bus;
        RDY    = rdy;
        irqL   = irqIn;
        @(posedge NMI_L);
        modelStep(bus, rdy, irqIn);
        @(negedge NMI_L);
        compareModel();                     // Outputs settled by now
    endtask

    // One instruction from sync to the next sync
    task automatic runInstruction(input int rdyLowPct, input logic irqPulse,
                                  input logic forceStore, output logic [7:0] offered,
                                  output logic [7:0] seenIr, output int seenLen,
                                  output int takenCount);
        logic [7:0] expIr;
        logic       rdy;
        logic       adv;
        logic       fetch;
        int         writes;
        int         guard;
        offered = 8'($random(seed));
        if (forceStore) offered[7:5] = 3'b100;  // STA/STX/STY space
        seenIr = 8'h00;
        seenLen = 0;
        takenCount = 0;
        writes = 0;
        guard = 0;
        while (!(seenLen > 0 && sync)) begin
            guard = guard + 1;
            if (guard > 200) reportTimeout("instruction never returned to T0");
            rdy   = ({$random(seed)} % 100) >= rdyLowPct;
            adv   = rdy | ~nRW;
            fetch = adv & sync;
            expIr = mPending ? 8'h00 : offered;
            if (!nRW) writes = writes + 1;  // Write cycles always advance
            stepCycle(sync ? offered : 8'($random(seed)), rdy, !(irqPulse && guard == 1));
            if (fetch) begin
                checkValue("ir", 32'(ir.raw), 32'(expIr));
                seenIr = ir.raw;
            end
            if (adv) seenLen = seenLen + 1;
            if (irqTaken) takenCount = takenCount + 1;
        end
        checkValue("cycles", 32'(seenLen), 32'(lengthOf(mIr)));
        checkValue("writes", 32'(writes),
                   32'(mIr[7:5] == 3'b100 && mIr[1:0] != 2'b11 && lengthOf(mIr) > 2));
    endtask

    initial begin
        logic [7:0] offered;
        logic [7:0] seenIr;
        int         seenLen;
        int         taken;
        seed   = 69855;
        rstN   = 1'b0;
        dataIn = 8'h00;
        RDY    = 1'b1;
        irqL   = 1'b1;
        modelReset();
        repeat (4) @(negedge NMI_L);        // Four rising edges in reset
        checkValue("tState", 32'(tState), 32'd1);
        checkValue("sync", 32'(sync), 32'd1);
        checkValue("nRW", 32'(nRW), 32'd1);
        checkValue("irqTaken", 32'(irqTaken), 32'd0);
        rstN = 1'b1;
        repeat (60) runInstruction(0, 1'b0, 1'b0, offered, seenIr, seenLen, taken);
        repeat (40) runInstruction(0, 1'b0, 1'b1, offered, seenIr, seenLen, taken);
        repeat (60) runInstruction(40, 1'b0, 1'b0, offered, seenIr, seenLen, taken);
        repeat (40) runInstruction(50, 1'b0, 1'b1, offered, seenIr, seenLen, taken);
        repeat (8) begin
            // Pulse during a normal fetch so that the break follows
            runInstruction(0, 1'b1, 1'b0, offered, seenIr, seenLen, taken);
            checkValue("ir", 32'(seenIr), 32'(offered));
            runInstruction(0, 1'b0, 1'b0, offered, seenIr, seenLen, taken);
            checkValue("ir", 32'(seenIr), 32'h00);
            checkValue("cycles", 32'(seenLen), 32'd6);
            checkValue("irqTaken", 32'(taken), 32'd1);
            runInstruction(0, 1'b0, 1'b0, offered, seenIr, seenLen, taken);
            checkValue("ir", 32'(seenIr), 32'(offered));
            checkValue("irqTaken", 32'(taken), 32'd0);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: files.f
+incdir+test
src/opcodePkg.sv
src/timingPkg.sv
src/fetchStage.sv
src/timingSequencer.sv
src/decodePla.sv
src/frontEndTop.sv
test/frontEndTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the front end testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f files.f --top-module frontEndTb -o simFrontEnd

# The run can stop on an error, so the log decides
./obj_dir/simFrontEnd 2>&1 | tee sim.log || true

grep -q "^PASS: all tests$" sim.log
